/* Makefile */
TOP = rvPipelineTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* dv/rvPipelineTb.sv */
// Testbench for the RV32I front end; drives random instructions under credit flow and checks retires.
`timescale 1ns/1ps

module rvPipelineTb import rvCorePkg::*; ();
    localparam int NUM_INSNS = 200;
    localparam int QUIET_STEPS = 5;
    localparam int TIMEOUT_CYCLES = 10 * NUM_INSNS + 200;

    typedef struct packed {
        word_t    pc;
        regAddr_t dst;
        logic     write;
        word_t    value;
        logic     trap;
        insn_t    trapValue;
    } retireRec_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     insnValid;
    insn_t    insn;
    logic     insnCredit;
    logic     retireCreditReturn;
    logic     retireValid;
    word_t    retirePc;
    regAddr_t retireDst;
    logic     retireWrite;
    word_t    retireValue;
    logic     retireTrap;
    word_t    retireTrapValue;

    logic [31:0] lcgState;
    word_t       refRegs [32];
    retireRec_t  expQueue [$];
    int srcCredits = FETCH_DEPTH;
    int retireCredits = RETIRE_CREDITS;
    int sentCount = 0;
    int retiredCount = 0;
    int returnedCount = 0;
    int stepCount = 0;
    int cycleCount = 0;
    logic pushedAny = 1'b0;

    rvPipelineTop uut (
        .clk(clk), .reset(reset), .insnValid(insnValid), .insn(insn),
        .insnCredit(insnCredit), .retireCreditReturn(retireCreditReturn),
        .retireValid(retireValid), .retirePc(retirePc), .retireDst(retireDst),
        .retireWrite(retireWrite), .retireValue(retireValue), .retireTrap(retireTrap),
        .retireTrapValue(retireTrapValue)
    );

    always #20 clk = ~clk;

    // the state halves are swapped so that small moduli use the better upper bits.
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {lcgState[15:0], lcgState[31:16]};
    endfunction

    task automatic reportMismatch(input string testName, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("MISMATCH %s expected 0x%08h actual 0x%08h", testName, expected, actual);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic reportFailure(input string reason);
        $display("ERROR %s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // builds one instruction, works out its retire record and puts it on the port.
    task automatic genInstruction();
        int unsigned pick;
        logic [31:0] noise;
        regAddr_t    rd;
        regAddr_t    rs1;
        regAddr_t    rs2;
        word_t       a;
        word_t       b;
        word_t       immExt;
        word_t       result;
        insn_t       word;
        retireRec_t  rec;
        pick = nextRand() % 12;
        rd = regAddr_t'(nextRand() % 8);
        rs1 = regAddr_t'(nextRand() % 8);
        rs2 = regAddr_t'(nextRand() % 8);
        noise = nextRand();
        a = refRegs[rs1];
        b = refRegs[rs2];
        immExt = {{20{noise[11]}}, noise[11:0]};
        rec = '0;
        rec.pc = word_t'(sentCount) << 2;
        rec.dst = rd;
        rec.write = (rd != 5'd0);
        case (pick)
            0: word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            1: word = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            2: word = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            3: word = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            4: word = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            5: word = {noise[11:0], rs1, 3'b000, rd, 7'b0010011};
            6: word = {noise[11:0], rs1, 3'b111, rd, 7'b0010011};
            7: word = {noise[11:0], rs1, 3'b110, rd, 7'b0010011};
            8: word = {noise[11:0], rs1, 3'b100, rd, 7'b0010011};
            9: word = {noise[31:12], rd, 7'b0110111};
            // a branch opcode or a multiply, neither of which this core implements.
            10: word = {noise[24:0], 7'b1100011};
            default: word = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
        endcase
        case (pick)
            0: result = a + b;
            1: result = a - b;
            2: result = a & b;
            3: result = a | b;
            4: result = a ^ b;
            5: result = a + immExt;
            6: result = a & immExt;
            7: result = a | immExt;
            8: result = a ^ immExt;
            9: result = {noise[31:12], 12'b0};
            default: result = '0;
        endcase
        if (pick >= 10) begin
            rec.trap = 1'b1;
            rec.trapValue = word;
            rec.write = 1'b0;
        end
        rec.value = rec.write ? result : '0;
        if (rec.write) begin
            refRegs[rd] = result;
        end
        expQueue.push_back(rec);
        insn = word;
        insnValid = 1'b1;
        sentCount++;
    endtask

    task automatic checkRetire();
        retireRec_t exp;
        string      tag;
        if (expQueue.size() == 0) begin
            reportFailure("an instruction retired that was never sent");
        end else begin
            exp = expQueue.pop_front();
            tag = $sformatf("insn %0d", retiredCount);
            assert (retirePc == exp.pc)
                else reportMismatch({tag, " retirePc"}, exp.pc, retirePc);
            assert (retireTrap == exp.trap)
                else reportMismatch({tag, " retireTrap"}, 32'(exp.trap), 32'(retireTrap));
            assert (retireWrite == exp.write)
                else reportMismatch({tag, " retireWrite"}, 32'(exp.write), 32'(retireWrite));
            if (exp.trap) begin
                assert (retireTrapValue == exp.trapValue)
                    else reportMismatch({tag, " retireTrapValue"}, exp.trapValue, retireTrapValue);
            end
            if (exp.write) begin
                assert (retireDst == exp.dst)
                    else reportMismatch({tag, " retireDst"}, 32'(exp.dst), 32'(retireDst));
                assert (retireValue == exp.value)
                    else reportMismatch({tag, " retireValue"}, exp.value, retireValue);
            end
        end
    endtask

    // credit bookkeeping for both ports, seen from the source and the sink.
    always @(posedge clk) begin
        if (reset) begin
            srcCredits <= FETCH_DEPTH;
            retireCredits <= RETIRE_CREDITS;
            retiredCount <= 0;
            pushedAny <= 1'b0;
        end else begin
            srcCredits <= srcCredits - int'(insnValid) + int'(insnCredit);
            retireCredits <= retireCredits - int'(retireValid) + int'(retireCreditReturn);
            if (insnValid) begin
                pushedAny <= 1'b1;
            end
            if (retireValid) begin
                checkRetire();
                retiredCount <= retiredCount + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            reportFailure("timeout, the pipeline did not drain within the cycle limit");
        end
    end

    noFireWithoutCredit: assert property (
        @(posedge clk) disable iff (reset) retireValid |-> (retireCredits != 0)
    ) else reportFailure("retireValid was high while the sink held no retire credit");

    sourceCreditBound: assert property (
        @(posedge clk) disable iff (reset) srcCredits <= FETCH_DEPTH
    ) else reportFailure("insnCredit pulses raised the source credits above the queue depth");

    quietAfterReset: assert property (
        @(posedge clk) disable iff (reset) !pushedAny |-> (!retireValid && !insnCredit)
    ) else reportFailure("retire or credit activity before the first instruction was sent");

    initial begin
        lcgState = 32'd86907;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        reset = 1'b1;
        insnValid = 1'b0;
        insn = '0;
        retireCreditReturn = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (!(retiredCount == NUM_INSNS && returnedCount == retiredCount)) begin
            insnValid = 1'b0;
            if (sentCount < NUM_INSNS && stepCount >= QUIET_STEPS && srcCredits > 0 &&
                (nextRand() % 4) != 0) begin
                genInstruction();
            end
            // the sink withholds every credit for a while to back the pipe up.
            retireCreditReturn = 1'b0;
            if (retiredCount > returnedCount && !(stepCount >= 120 && stepCount < 180) &&
                (nextRand() % 4) == 0) begin
                retireCreditReturn = 1'b1;
                returnedCount++;
            end
            stepCount++;
            @(negedge clk);
        end
        insnValid = 1'b0;
        retireCreditReturn = 1'b0;
        repeat (4) @(negedge clk);
        assert (expQueue.size() == 0)
            else reportFailure("instructions were still outstanding after the drain");
        assert (srcCredits == FETCH_DEPTH)
            else reportMismatch("final source credits", 32'(FETCH_DEPTH), 32'(srcCredits));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* hw/decodeStage.sv */
// Decode stage: classifies the fetched word, flags illegal encodings and registers the result.
`timescale 1ns/1ps

module decodeStage import rvCorePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       fbValid,
    input  insn_t      fbInsn,
    input  word_t      fbPc,
    input  logic       idStall,
    output logic       idValid,
    output opKind_t    idOp,
    output regAddr_t   idRs1,
    output regAddr_t   idRs2,
    output regAddr_t   idRd,
    output word_t      idImm,
    output insn_t      idInsn,
    output word_t      idPc,
    output trapCause_t idTrap
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    opKind_t    decOp;
    word_t      decImm;
    trapCause_t decTrap;

    always_comb begin
        opcode = fbInsn[6:0];
        funct3 = fbInsn[14:12];
        funct7 = fbInsn[31:25];
        decOp = opIllegal;
        decImm = '0;
        case (opcode)
            OPCODE_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: decOp = opAdd;
                        F3_XOR:     decOp = opXor;
                        F3_OR:      decOp = opOr;
                        F3_AND:     decOp = opAnd;
                        default: ;
                    endcase
                end else if (funct7 == F7_ALT && funct3 == F3_ADD_SUB) begin
                    decOp = opSub;
                end
            end
            OPCODE_OP_IMM: begin
                // I-type immediate, sign extended from bit 31.
                decImm = {{20{fbInsn[31]}}, fbInsn[31:20]};
                case (funct3)
                    F3_ADD_SUB: decOp = opAddi;
                    F3_XOR:     decOp = opXori;
                    F3_OR:      decOp = opOri;
                    F3_AND:     decOp = opAndi;
                    default: ;
                endcase
            end
            OPCODE_LUI: begin
                decOp = opLui;
                decImm = {fbInsn[31:12], 12'b0};
            end
            default: ;
        endcase
        decTrap = (decOp == opIllegal) ? causeIllegalInsn : causeNone;
    end

    // registers hold their contents while execute cannot accept them.
    always_ff @(posedge clk) begin
        if (reset || (!idStall && !fbValid)) begin
            idValid <= 1'b0;
            idOp <= opIllegal;
            idRs1 <= '0;
            idRs2 <= '0;
            idRd <= '0;
            idImm <= '0;
            idInsn <= '0;
            idPc <= '0;
            idTrap <= causeNone;
        end else if (!idStall) begin
            idValid <= 1'b1;
            idOp <= decOp;
            idRs1 <= fbInsn[19:15];
            idRs2 <= fbInsn[24:20];
            idRd <= fbInsn[11:7];
            idImm <= decImm;
            idInsn <= fbInsn;
            idPc <= fbPc;
            idTrap <= decTrap;
        end
    end

    // a head refused under a stall must still be waiting at the next edge, or it would be lost.
    stableDuringStall: assert property (
        @(posedge clk) disable iff (reset)
        (idStall && fbValid) |=> (fbValid && $stable({fbInsn, fbPc}))
    ) else $error("fetch head changed while decode was stalled");

endmodule

/* hw/executeStage.sv */
// Execute stage: reads operands, computes the ALU result, writes back and holds the retire record.
`timescale 1ns/1ps

module executeStage import rvCorePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       idValid,
    input  opKind_t    idOp,
    input  regAddr_t   idRs1,
    input  regAddr_t   idRs2,
    input  regAddr_t   idRd,
    input  word_t      idImm,
    input  insn_t      idInsn,
    input  word_t      idPc,
    input  trapCause_t idTrap,
    input  logic       exStall,
    output logic       exValid,
    output word_t      retirePc,
    output regAddr_t   retireDst,
    output logic       retireWrite,
    output word_t      retireValue,
    output logic       retireTrap,
    output word_t      retireTrapValue
);
    word_t rs1Data;
    word_t rs2Data;
    word_t aluResult;
    logic  isTrap;
    logic  writeBack;

    // results are committed as the record leaves, so the next
    // instruction entering at that edge picks them up through the bypass.
    assign writeBack = exValid && !exStall && retireWrite;

    registerFile regFile (
        .clk      (clk),
        .reset    (reset),
        .rs1      (idRs1),
        .rs2      (idRs2),
        .writeEn  (writeBack),
        .writeAddr(retireDst),
        .writeData(retireValue),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data)
    );

    assign isTrap = (idTrap != causeNone);

    always_comb begin
        case (idOp)
            opAdd:   aluResult = rs1Data + rs2Data;
            opSub:   aluResult = rs1Data - rs2Data;
            opAnd:   aluResult = rs1Data & rs2Data;
            opOr:    aluResult = rs1Data | rs2Data;
            opXor:   aluResult = rs1Data ^ rs2Data;
            opAddi:  aluResult = rs1Data + idImm;
            opAndi:  aluResult = rs1Data & idImm;
            opOri:   aluResult = rs1Data | idImm;
            opXori:  aluResult = rs1Data ^ idImm;
            opLui:   aluResult = idImm;
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
        end else if (!exStall) begin
            exValid <= idValid;
        end
    end

    // the record is held unchanged until the controller lets it retire.
    always_ff @(posedge clk) begin
        if (!exStall) begin
            retirePc <= idPc;
            retireDst <= idRd;
            retireWrite <= idValid && !isTrap && (idRd != '0);
            retireValue <= isTrap ? '0 : aluResult;
            retireTrap <= idValid && isTrap;
            retireTrapValue <= isTrap ? idInsn : '0;
        end
    end

endmodule

/* hw/fetchBuffer.sv */
// Credit-fed instruction queue that tags each entry with its PC and returns a credit per pop.
`timescale 1ns/1ps

module fetchBuffer import rvCorePkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  insnValid,
    input  insn_t insn,
    input  logic  idStall,
    output logic  fbValid,
    output insn_t fbInsn,
    output word_t fbPc,
    output logic  insnCredit
);
    insn_t    insnMem [FETCH_DEPTH];
    word_t    pcMem [FETCH_DEPTH];
    fbPtr_t   wrPtr;
    fbPtr_t   rdPtr;
    fbCount_t count;
    word_t    nextPc;
    logic     pop;

    assign fbValid = (count != '0);
    assign fbInsn = insnMem[rdPtr];
    assign fbPc = pcMem[rdPtr];

    // the head leaves whenever decode is free to take it.
    assign pop = fbValid && !idStall;

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            nextPc <= '0;
            insnCredit <= 1'b0;
        end else begin
            if (insnValid) begin
                wrPtr <= wrPtr + 1'b1;
                nextPc <= nextPc + 32'd4;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({insnValid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
            // one credit goes back to the source for every entry freed.
            insnCredit <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (insnValid) begin
            insnMem[wrPtr] <= insn;
            pcMem[wrPtr] <= nextPc;
        end
    end

    // a push into a full queue means the source sent without a credit.
    pushWhileFull: assert property (
        @(posedge clk) disable iff (reset) insnValid |-> (count != FB_FULL)
    ) else $error("fetch buffer push while full");

endmodule

/* hw/pipelineController.sv */
// Pipeline controller: owns the retire credit count and derives every stall in the core.
`timescale 1ns/1ps

module pipelineController import rvCorePkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic idValid,
    input  logic exValid,
    input  logic retireCreditReturn,
    output logic retireFire,
    output logic exStall,
    output logic idStall
);
    creditCount_t credits;

    // an instruction retires only when the sink has room for it.
    assign retireFire = exValid && (credits != '0);

    // execute holds when it has a record that cannot leave.
    assign exStall = exValid && !retireFire;

    // decode backs up only if execute is full and blocked.
    assign idStall = idValid && exStall;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= RETIRE_CREDIT_MAX;
        end else begin
            // a spend and a return in the same cycle cancel out.
            case ({retireFire, retireCreditReturn})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    // the sink may never hand back more credits than it was given.
    creditOverflow: assert property (
        @(posedge clk) disable iff (reset)
        (retireCreditReturn && !retireFire) |-> (credits != RETIRE_CREDIT_MAX)
    ) else $error("retire credit returned beyond the initial count");

    creditBound: assert property (
        @(posedge clk) disable iff (reset) credits <= RETIRE_CREDIT_MAX
    ) else $error("retire credit count above its limit");

endmodule

/* hw/registerFile.sv */
// Integer register file with x0 hardwired to zero and the write port bypassed to both reads.
`timescale 1ns/1ps

module registerFile import rvCorePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t rs1,
    input  regAddr_t rs2,
    input  logic     writeEn,
    input  regAddr_t writeAddr,
    input  word_t    writeData,
    output word_t    rs1Data,
    output word_t    rs2Data
);
    word_t regs [32];

    // the bypass lets a reader see the value being written in the same cycle.
    function automatic word_t readPort(input regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (writeEn && writeAddr == addr) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    assign rs1Data = readPort(rs1);
    assign rs2Data = readPort(rs2);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

/* hw/rvCorePkg.sv */
// Shared types, encodings and depth constants for the RV32I front-end core; imported by every RTL block.
package rvCorePkg;

    typedef logic [31:0] insn_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // wide enough to count either the fetch credits or the retire credits.
    typedef logic [2:0]  creditCount_t;

    localparam int FETCH_DEPTH = 4;
    localparam int RETIRE_CREDITS = 2;
    localparam int FB_PTR_W = $clog2(FETCH_DEPTH);

    typedef logic [FB_PTR_W-1:0] fbPtr_t;
    typedef logic [FB_PTR_W:0]   fbCount_t;

    localparam fbCount_t     FB_FULL = fbCount_t'(FETCH_DEPTH);
    localparam creditCount_t RETIRE_CREDIT_MAX = creditCount_t'(RETIRE_CREDITS);

    // major opcodes of the supported instruction groups.
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 selects between ADD and SUB for register operations.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        opAdd, opSub, opAnd, opOr, opXor,
        opAddi, opAndi, opOri, opXori, opLui,
        opIllegal
    } opKind_t;

    typedef enum logic [3:0] {
        causeNone        = 4'd0,
        causeIllegalInsn = 4'd2
    } trapCause_t;

endpackage

/* hw/rvPipelineTop.sv */
// Top level of the RV32I front end; connects the credit-based instruction and retire ports.
`timescale 1ns/1ps

module rvPipelineTop import rvCorePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     insnValid,
    input  insn_t    insn,
    output logic     insnCredit,
    input  logic     retireCreditReturn,
    output logic     retireValid,
    output word_t    retirePc,
    output regAddr_t retireDst,
    output logic     retireWrite,
    output word_t    retireValue,
    output logic     retireTrap,
    output word_t    retireTrapValue
);
    logic       fbValid;
    insn_t      fbInsn;
    word_t      fbPc;
    logic       idValid;
    opKind_t    idOp;
    regAddr_t   idRs1;
    regAddr_t   idRs2;
    regAddr_t   idRd;
    word_t      idImm;
    insn_t      idInsn;
    word_t      idPc;
    trapCause_t idTrap;
    logic       exValid;
    logic       exStall;
    logic       idStall;

    fetchBuffer fetch (
        .clk(clk), .reset(reset),
        .insnValid(insnValid), .insn(insn), .idStall(idStall),
        .fbValid(fbValid), .fbInsn(fbInsn), .fbPc(fbPc), .insnCredit(insnCredit)
    );

    decodeStage decode (
        .clk(clk), .reset(reset),
        .fbValid(fbValid), .fbInsn(fbInsn), .fbPc(fbPc), .idStall(idStall),
        .idValid(idValid), .idOp(idOp), .idRs1(idRs1), .idRs2(idRs2), .idRd(idRd),
        .idImm(idImm), .idInsn(idInsn), .idPc(idPc), .idTrap(idTrap)
    );

    // retireValid is the controller's fire decision itself.
    pipelineController controller (
        .clk(clk), .reset(reset),
        .idValid(idValid), .exValid(exValid), .retireCreditReturn(retireCreditReturn),
        .retireFire(retireValid), .exStall(exStall), .idStall(idStall)
    );

    executeStage execute (
        .clk(clk), .reset(reset),
        .idValid(idValid), .idOp(idOp), .idRs1(idRs1), .idRs2(idRs2), .idRd(idRd),
        .idImm(idImm), .idInsn(idInsn), .idPc(idPc), .idTrap(idTrap),
        .exStall(exStall), .exValid(exValid),
        .retirePc(retirePc), .retireDst(retireDst), .retireWrite(retireWrite),
        .retireValue(retireValue), .retireTrap(retireTrap),
        .retireTrapValue(retireTrapValue)
    );

endmodule

/* project.f */
hw/rvCorePkg.sv
hw/fetchBuffer.sv
hw/decodeStage.sv
hw/pipelineController.sv
hw/registerFile.sv
hw/executeStage.sv
hw/rvPipelineTop.sv
dv/rvPipelineTb.sv
